/* src/core_settings.svh */
/*
 * Core-wide settings
 * Reset PC, word width, register count and register index width
 */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define RESET_PC   32'h0000_0000  // First fetch address
`define XLEN       32             // Data and address width
`define NUM_REGS   32             // General purpose registers
`define REG_ADDR_W 5              // Bits to index NUM_REGS

`endif

/* src/isa_pkg.sv */
/*
 * RV32I instruction set types
 * Word and register index types, opcode map,
 * ALU operations and branch conditions
 */
`default_nettype none
`include "core_settings.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0]       word_t;      // Data and address word
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // GPR index

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // Register-register ALU
    OPC_OP_IMM = 7'b0010011,  // Register-immediate ALU
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_PASS_B                                   // LUI result is the immediate
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU,
    BR_JUMP                                      // JAL and JALR
  } br_cond_e;

endpackage

`default_nettype wire

/* src/pipe_pkg.sv */
/*
 * Pipeline register layouts
 * IF/ID, ID/IS, IS/EX and the writeback bundle
 */
`default_nettype none

package pipe_pkg;
  import isa_pkg::*;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     instr;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    logic      rd_we;      // Never set for x0
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    logic      a_sel_pc;   // A operand is the PC
    logic      b_sel_imm;  // B operand is the immediate
    alu_op_e   alu_op;
    br_cond_e  br_cond;
    logic      link;       // Writes pc+4
    logic [1:0] fwd_is;    // Bit 0 rs1, bit 1 rs2
    logic [1:0] fwd_ex;    // Same order
  } id_is_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    logic      rd_we;
    word_t     op_a;
    word_t     op_b;
    word_t     rs1_val;    // Raw values for branch compare
    word_t     rs2_val;
    word_t     imm;
    alu_op_e   alu_op;
    br_cond_e  br_cond;
    logic      link;
    logic [1:0] fwd_ex;
  } is_ex_t;

  typedef struct packed {
    logic      valid;      // Write rd this cycle
    reg_addr_t rd;
    word_t     data;
    word_t     pc;
  } wb_t;

endpackage

`default_nettype wire

/* src/fetch_unit.sv */
/*
 * Fetch stage
 * Program counter with redirect and the IF/ID register
 */
`default_nettype none
`timescale 1ns/1ns
`include "core_settings.svh"

module fetch_unit import isa_pkg::*, pipe_pkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   redirect,   // Taken transfer from execute
  input  word_t  target,
  output word_t  ins_addr,
  input  word_t  ins_data,   // Same-cycle answer from memory
  output if_id_t if_id
);

  word_t pc;

  assign ins_addr = pc;

  always_ff @(posedge clock) begin
    if (reset) pc <= `RESET_PC;
    else if (redirect) pc <= target;          // Resolved in execute
    else pc <= pc + word_t'(4);               // Always predict not-taken
  end

  always_ff @(posedge clock) begin
    if_id.valid <= !(reset || redirect);      // Kill the youngest slot
    if_id.pc    <= pc;
    if_id.instr <= ins_data;
  end

  // The PC stays on a word boundary, redirects included
  a_pc_aligned: assert property (@(posedge clock) disable iff (reset)
    pc[1:0] == 2'b00)
    else $error("PC not word aligned pc=%h", pc);

endmodule

`default_nettype wire

/* src/gpr_file.sv */
/*
 * General purpose register file
 * 32 x 32, two async read ports, one write port from writeback
 */
`default_nettype none
`timescale 1ns/1ns
`include "core_settings.svh"

module gpr_file import isa_pkg::*, pipe_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  wb_t       wb            // Writeback bundle
);

  word_t regs [`NUM_REGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;     // x0 stays zero
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];  // Hardwired zero
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* src/decode_unit.sv */
/*
 * Decode stage
 * Opcode and funct decode, immediates, forward select generation,
 * distance-3 forward muxes and the ID/IS register
 */
`default_nettype none
`timescale 1ns/1ns

module decode_unit import isa_pkg::*, pipe_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  if_id_t    if_id,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  wb_t       wb,
  input  logic      redirect,
  output id_is_t    id_is
);

  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt, input logic is_op);
    case (f3)
      3'b000:  alu_sel = (is_op && alt) ? ALU_SUB : ALU_ADD;  // No SUBI
      3'b001:  alu_sel = ALU_SLL;
      3'b010:  alu_sel = ALU_SLT;
      3'b011:  alu_sel = ALU_SLTU;
      3'b100:  alu_sel = ALU_XOR;
      3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_sel = ALU_OR;
      default: alu_sel = ALU_AND;
    endcase
  endfunction

  function automatic logic fwd_hit(input reg_addr_t src, input logic we, input reg_addr_t dst);
    fwd_hit = we && (src == dst) && (src != '0);
  endfunction

  opcode_e   opc;
  logic [2:0] funct3;
  reg_addr_t rd;
  word_t     imm_i, imm_u, imm_b, imm_j, imm;
  logic      known, writes, uses_rs1, uses_rs2, a_sel_pc, b_sel_imm, link;
  alu_op_e   alu_op;
  br_cond_e  br_cond;
  logic      d2_we;          // Mirror of IS/EX valid and rd_we
  reg_addr_t d2_rd;
  logic [1:0] hit_d1, hit_d2, hit_d3;

  assign opc    = opcode_e'(if_id.instr[6:0]);
  assign funct3 = if_id.instr[14:12];
  assign rd     = if_id.instr[11:7];
  assign rs1    = if_id.instr[19:15];  // To GPR read ports
  assign rs2    = if_id.instr[24:20];

  // ----------------------------------------------------------
  // Immediates
  assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
  assign imm_u = {if_id.instr[31:12], 12'b0};
  assign imm_b = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                  if_id.instr[30:25], if_id.instr[11:8], 1'b0};
  assign imm_j = {{11{if_id.instr[31]}}, if_id.instr[31], if_id.instr[19:12],
                  if_id.instr[20], if_id.instr[30:21], 1'b0};

  always_comb begin
    known = 1'b1;
    writes = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    a_sel_pc = 1'b0;
    b_sel_imm = 1'b0;
    link = 1'b0;
    imm = imm_i;
    alu_op = ALU_ADD;
    br_cond = BR_NONE;
    case (opc)
      OPC_OP: begin
        writes = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        alu_op = alu_sel(funct3, if_id.instr[30], 1'b1);
      end
      OPC_OP_IMM: begin
        writes = 1'b1;
        uses_rs1 = 1'b1;
        b_sel_imm = 1'b1;
        alu_op = alu_sel(funct3, if_id.instr[30], 1'b0);  // Bit 30 only picks SRAI
      end
      OPC_LUI: begin
        writes = 1'b1;
        b_sel_imm = 1'b1;
        imm = imm_u;
        alu_op = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        writes = 1'b1;
        a_sel_pc = 1'b1;
        b_sel_imm = 1'b1;
        imm = imm_u;
      end
      OPC_JAL: begin
        writes = 1'b1;
        link = 1'b1;
        a_sel_pc = 1'b1;     // ALU forms pc+imm as target
        b_sel_imm = 1'b1;
        imm = imm_j;
        br_cond = BR_JUMP;
      end
      OPC_JALR: begin
        writes = 1'b1;
        link = 1'b1;
        uses_rs1 = 1'b1;
        b_sel_imm = 1'b1;    // ALU forms rs1+imm as target
        br_cond = BR_JUMP;
      end
      OPC_BRANCH: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        imm = imm_b;
        case (funct3)
          3'b000:  br_cond = BR_EQ;
          3'b001:  br_cond = BR_NE;
          3'b100:  br_cond = BR_LT;
          3'b101:  br_cond = BR_GE;
          3'b110:  br_cond = BR_LTU;
          3'b111:  br_cond = BR_GEU;
          default: br_cond = BR_NONE;  // Reserved funct3 falls through
        endcase
      end
      default: known = 1'b0;           // Becomes a bubble
    endcase
  end

  // ----------------------------------------------------------
  // Forward selects for register-sourced operands only
  assign hit_d1[0] = uses_rs1 && fwd_hit(rs1, id_is.valid && id_is.rd_we, id_is.rd);
  assign hit_d1[1] = uses_rs2 && fwd_hit(rs2, id_is.valid && id_is.rd_we, id_is.rd);
  assign hit_d2[0] = uses_rs1 && fwd_hit(rs1, d2_we, d2_rd);
  assign hit_d2[1] = uses_rs2 && fwd_hit(rs2, d2_we, d2_rd);
  assign hit_d3[0] = uses_rs1 && fwd_hit(rs1, wb.valid, wb.rd);
  assign hit_d3[1] = uses_rs2 && fwd_hit(rs2, wb.valid, wb.rd);

  always_ff @(posedge clock) begin
    d2_we <= !(reset || redirect) && id_is.valid && id_is.rd_we;  // Follows IS/EX
    d2_rd <= id_is.rd;
  end

  always_ff @(posedge clock) begin
    id_is.valid     <= !(reset || redirect) && if_id.valid && known;
    id_is.pc        <= if_id.pc;
    id_is.rd        <= rd;
    id_is.rd_we     <= writes && (rd != '0);
    id_is.rs1_val   <= hit_d3[0] ? wb.data : rs1_data;  // Distance 3 resolved here
    id_is.rs2_val   <= hit_d3[1] ? wb.data : rs2_data;
    id_is.imm       <= imm;
    id_is.a_sel_pc  <= a_sel_pc;
    id_is.b_sel_imm <= b_sel_imm;
    id_is.alu_op    <= alu_op;
    id_is.br_cond   <= br_cond;
    id_is.link      <= link;
    id_is.fwd_is    <= hit_d2;
    id_is.fwd_ex    <= hit_d1;
  end

  // Only the known opcode arms of the decode table may set writes
  a_unknown_no_write: assert property (@(posedge clock) disable iff (reset)
    (if_id.valid && !known) |=> !id_is.rd_we)
    else $error("Unknown opcode set rd_we rd=%h", id_is.rd);

endmodule

`default_nettype wire

/* src/issue_unit.sv */
/*
 * Issue stage
 * Distance-2 forward muxes, A/B operand select and the IS/EX register
 */
`default_nettype none
`timescale 1ns/1ns

module issue_unit import isa_pkg::*, pipe_pkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  id_is_t id_is,
  input  wb_t    wb,          // Only the data is used here
  input  logic   redirect,
  output is_ex_t is_ex
);

  word_t rs1_val;
  word_t rs2_val;
  word_t op_a;
  word_t op_b;

  // ----------------------------------------------------------
  // Forward from writeback for the instruction two ahead
  assign rs1_val = id_is.fwd_is[0] ? wb.data : id_is.rs1_val;
  assign rs2_val = id_is.fwd_is[1] ? wb.data : id_is.rs2_val;

  assign op_a = id_is.a_sel_pc  ? id_is.pc  : rs1_val;  // AUIPC and JAL
  assign op_b = id_is.b_sel_imm ? id_is.imm : rs2_val;  // OP-IMM, LUI, jumps

  always_ff @(posedge clock) begin
    is_ex.valid   <= !(reset || redirect) && id_is.valid;  // Flush second slot
    is_ex.pc      <= id_is.pc;
    is_ex.rd      <= id_is.rd;
    is_ex.rd_we   <= id_is.rd_we;
    is_ex.op_a    <= op_a;
    is_ex.op_b    <= op_b;
    is_ex.rs1_val <= rs1_val;       // Kept raw for the compare
    is_ex.rs2_val <= rs2_val;
    is_ex.imm     <= id_is.imm;
    is_ex.alu_op  <= id_is.alu_op;
    is_ex.br_cond <= id_is.br_cond;
    is_ex.link    <= id_is.link;
    is_ex.fwd_ex  <= id_is.fwd_ex;
  end

endmodule

`default_nettype wire

/* src/exec_unit.sv */
/*
 * Execute stage
 * Distance-1 forward muxes, ALU, branch resolution,
 * writeback value select and the EX/WB register
 */
`default_nettype none
`timescale 1ns/1ns

module exec_unit import isa_pkg::*, pipe_pkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  is_ex_t is_ex,
  input  wb_t    wb_fwd,      // Previous result for forwarding
  output wb_t    wb_out,      // EX/WB register
  output logic   redirect,
  output word_t  target
);

  word_t op_a, op_b, rs1_val, rs2_val, alu_res;
  logic  cond;

  // Decode only sets fwd_ex bits for register-sourced operands
  assign op_a    = is_ex.fwd_ex[0] ? wb_fwd.data : is_ex.op_a;
  assign op_b    = is_ex.fwd_ex[1] ? wb_fwd.data : is_ex.op_b;
  assign rs1_val = is_ex.fwd_ex[0] ? wb_fwd.data : is_ex.rs1_val;
  assign rs2_val = is_ex.fwd_ex[1] ? wb_fwd.data : is_ex.rs2_val;

  // ----------------------------------------------------------
  // ALU
  always_comb begin
    case (is_ex.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   alu_res = word_t'(op_a < op_b);
      ALU_SLL:    alu_res = op_a << op_b[4:0];  // Low five bits only
      ALU_SRL:    alu_res = op_a >> op_b[4:0];
      ALU_SRA:    alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  always_comb begin
    case (is_ex.br_cond)
      BR_EQ:   cond = (rs1_val == rs2_val);
      BR_NE:   cond = (rs1_val != rs2_val);
      BR_LT:   cond = ($signed(rs1_val) < $signed(rs2_val));
      BR_GE:   cond = ($signed(rs1_val) >= $signed(rs2_val));
      BR_LTU:  cond = (rs1_val < rs2_val);
      BR_GEU:  cond = (rs1_val >= rs2_val);
      BR_JUMP: cond = 1'b1;
      default: cond = 1'b0;             // Not a transfer
    endcase
  end

  assign redirect = is_ex.valid && cond;
  assign target = (is_ex.br_cond == BR_JUMP) ? (alu_res & ~word_t'(1))  // Jumps use ALU sum
                                             : (is_ex.pc + is_ex.imm);

  always_ff @(posedge clock) begin
    wb_out.valid <= !reset && is_ex.valid && is_ex.rd_we;
    wb_out.rd    <= is_ex.rd;
    wb_out.data  <= is_ex.link ? (is_ex.pc + word_t'(4)) : alu_res;  // Link value
    wb_out.pc    <= is_ex.pc;
  end

  // The slot behind a taken transfer reaches execute as a bubble
  a_redirect_flush: assert property (@(posedge clock) disable iff (reset)
    redirect |=> !is_ex.valid)
    else $error("Valid instruction followed a redirect pc=%h", is_ex.pc);

endmodule

`default_nettype wire

/* src/core_top.sv */
/*
 * RV32I five-stage core top level
 * Fetch, decode with GPR file, issue and execute stages
 */
`default_nettype none
`timescale 1ns/1ns

module core_top import isa_pkg::*, pipe_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  output word_t     ins_addr,     // Instruction memory address
  input  word_t     ins_data,     // Word at ins_addr, same cycle
  output logic      wb_valid,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output word_t     wb_pc
);

  if_id_t    if_id;
  id_is_t    id_is;
  is_ex_t    is_ex;
  wb_t       wb;               // Shared writeback and forward bus
  reg_addr_t rs1, rs2;
  word_t     rs1_data, rs2_data;
  logic      redirect;
  word_t     target;

  fetch_unit u_fetch (
    .clock(clock), .reset(reset), .redirect(redirect), .target(target),
    .ins_addr(ins_addr), .ins_data(ins_data), .if_id(if_id)
  );

  gpr_file u_gpr (
    .clock(clock), .reset(reset), .rs1(rs1), .rs2(rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .wb(wb)
  );

  decode_unit u_decode (
    .clock(clock), .reset(reset), .if_id(if_id), .rs1(rs1), .rs2(rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .wb(wb),
    .redirect(redirect), .id_is(id_is)
  );

  issue_unit u_issue (
    .clock(clock), .reset(reset), .id_is(id_is), .wb(wb),
    .redirect(redirect), .is_ex(is_ex)
  );

  exec_unit u_exec (
    .clock(clock), .reset(reset), .is_ex(is_ex), .wb_fwd(wb), .wb_out(wb),
    .redirect(redirect), .target(target)
  );

  assign wb_valid = wb.valid;   // Retirement view
  assign wb_rd    = wb.rd;
  assign wb_data  = wb.data;
  assign wb_pc    = wb.pc;

endmodule

`default_nettype wire

/* bench/core_tb.sv */
/*
 * Testbench for the RV32I core
 * Clock, reset, instruction ROM, program builder, reference model,
 * per-edge expectations, checking assertions and watchdog
 */
`default_nettype none
`timescale 1ns/1ns
`include "core_settings.svh"

module core_tb import isa_pkg::*; ();

  localparam int ROM_WORDS = 256;
  localparam int MAX_SLOTS = 1024;

  logic      clock;
  logic      reset;
  word_t     ins_data = '0;
  word_t     ins_addr;
  logic      wb_valid;
  reg_addr_t wb_rd;
  word_t     wb_data;
  word_t     wb_pc;

  word_t     rom [ROM_WORDS];
  int        prog_len;
  integer    seed;
  word_t     end_pc;                        // Self loop that ends the program
  int        end_slot;
  int        model_len;
  int        limit_cycles = 0;

  // Reference model output, one slot per fetch cycle
  word_t     exp_addr_q [MAX_SLOTS];
  logic      exp_wv_q [MAX_SLOTS];
  reg_addr_t exp_rd_q [MAX_SLOTS];
  word_t     exp_data_q [MAX_SLOTS];
  word_t     shadow [`NUM_REGS];            // Architectural register state

  // Expectations for the next rising edge
  int        nedge = 0;
  logic      chk_reset = 1'b0;
  logic      chk_run = 1'b0;
  logic      exp_wv;
  word_t     exp_addr;
  reg_addr_t exp_rd;
  word_t     exp_data;
  word_t     exp_pc;
  int        err_reset = 0;
  int        err_fetch = 0;
  int        err_retire = 0;

  core_top DUT (
    .clock(clock), .reset(reset), .ins_addr(ins_addr), .ins_data(ins_data),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .wb_pc(wb_pc)
  );

  // ----------------------------------------------------------
  // Instruction encoders
  function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                  input logic [2:0] f3, input int rd);
    enc_r = {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
  endfunction

  function automatic word_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                  input int rd, input logic [6:0] opc);
    enc_i = {12'(imm), 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic word_t enc_u(input int imm, input int rd, input logic [6:0] opc);
    enc_u = {20'(imm), 5'(rd), opc};
  endfunction

  function automatic word_t enc_b(input int off, input int rs2, input int rs1,
                                  input logic [2:0] f3);
    logic [12:0] b;
    b = 13'(off);
    enc_b = {b[12], b[10:5], 5'(rs2), 5'(rs1), f3, b[4:1], b[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_j(input int off, input int rd);
    logic [20:0] j;
    j = 21'(off);
    enc_j = {j[20], j[10:1], j[11], j[19:12], 5'(rd), OPC_JAL};
  endfunction

  function automatic int pick(input int lo, input int span);
    pick = lo + int'($unsigned($random(seed)) % span);
  endfunction

  task automatic emit(input word_t w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  task automatic emit_fillers(input int base);
    for (int f = 0; f < 3; f++) begin
      emit(enc_i(base + f, 0, 3'b000, 27 + f, OPC_OP_IMM));  // Dies if skipped
    end
  endtask

  // ----------------------------------------------------------
  // Program builder
  task automatic build_program();
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = word_t'(i) << 7;              // Opcode 0, a bubble everywhere
    end
    prog_len = 0;
    for (int r = 1; r <= 8; r++) begin
      emit(enc_u($random(seed), r, OPC_LUI));
      emit(enc_i($random(seed), r, 3'b000, r, OPC_OP_IMM));  // Distance 1 on itself
    end
    emit(enc_u($random(seed), 9, OPC_AUIPC));
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, pick(1, 17), pick(1, 17), 3'(f), pick(10, 8)));
      if (f == 0 || f == 5) begin
        emit(enc_r(7'h20, pick(1, 17), pick(1, 17), 3'(f), pick(10, 8)));  // SUB, SRA
      end
    end
    for (int f = 0; f < 8; f++) begin
      if (f == 1 || f == 5) begin
        emit(enc_i(pick(0, 32), pick(1, 17), 3'(f), pick(10, 8), OPC_OP_IMM));
        if (f == 5) emit(enc_i('h400 + pick(0, 32), pick(1, 17), 3'(f), pick(10, 8),
                               OPC_OP_IMM));         // SRAI
      end else begin
        emit(enc_i($random(seed), pick(1, 17), 3'(f), pick(10, 8), OPC_OP_IMM));
      end
    end
    // Consumers at distance 1 to 4, first on rs1 and then on rs2
    for (int p = 0; p < 2; p++) begin
      for (int d = 1; d <= 4; d++) begin
        emit(enc_r(7'h00, d + 4 * p, 20, 3'b000, 20));
        for (int f = 1; f < d; f++) emit(enc_r(7'h00, 4, 3, 3'b100, 21));
        if (p == 0) emit(enc_r(7'h20, 5, 20, 3'b000, 22));
        else emit(enc_r(7'h00, 20, 6, 3'b111, 22));
      end
    end
    emit(enc_i(5, 1, 3'b000, 0, OPC_OP_IMM));        // Write to x0 is dropped
    emit(enc_r(7'h00, 0, 0, 3'b000, 23));
    emit(enc_r(7'h00, 2, 0, 3'b000, 24));
    emit(32'h0000_1200);                             // Unknown opcode
    emit(enc_u('h80000, 25, OPC_LUI));               // Negative operand
    emit(enc_i(pick(1, 2000), 0, 3'b000, 26, OPC_OP_IMM));
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      emit(enc_b(16, 26, 25, 3'(f)));
      emit_fillers(f * 8);
      emit(enc_b(16, 25, 26, 3'(f)));
      emit_fillers(f * 8 + 3);
      emit(enc_b(16, 26, 26, 3'(f)));                // Equal operands
      emit_fillers(f * 8 + 6);
    end
    emit(enc_j(16, 27));
    emit_fillers(100);
    emit(enc_u(0, 28, OPC_AUIPC));
    emit(enc_i(21, 28, 3'b000, 29, OPC_JALR));       // Odd offset, bit 0 dropped
    emit_fillers(110);
    emit(enc_r(7'h00, 29, 27, 3'b000, 30));
    end_pc = `RESET_PC + word_t'(prog_len * 4);
    emit(enc_j(0, 31));
  endtask

  // ----------------------------------------------------------
  // Reference model from the ISA rules
  function automatic word_t alu(input logic [2:0] f3, input logic alt,
                                input word_t a, input word_t b);
    case (f3)
      3'b000:  alu = alt ? a - b : a + b;
      3'b001:  alu = a << b[4:0];
      3'b010:  alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  alu = (a < b) ? 32'd1 : 32'd0;
      3'b100:  alu = a ^ b;
      3'b101:  alu = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  alu = a | b;
      default: alu = a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000:  branch_taken = (a == b);
      3'b001:  branch_taken = (a != b);
      3'b100:  branch_taken = ($signed(a) < $signed(b));
      3'b101:  branch_taken = ($signed(a) >= $signed(b));
      3'b110:  branch_taken = (a < b);
      default: branch_taken = (a >= b);
    endcase
  endfunction

  task automatic run_model();
    word_t pc;
    word_t instr;
    word_t val;
    word_t nxt;
    word_t a;
    word_t b;
    int    k;
    int    rd;
    logic  wr;
    logic  taken;
    for (int r = 0; r < `NUM_REGS; r++) shadow[r] = '0;
    pc = `RESET_PC;
    k = 0;
    end_slot = -1;
    while (k < MAX_SLOTS - 4 && (end_slot < 0 || k < end_slot + 12)) begin
      instr = rom[pc[9:2]];
      rd = int'(instr[11:7]);
      a = shadow[instr[19:15]];
      b = shadow[instr[24:20]];
      wr = 1'b1;
      taken = 1'b0;
      val = '0;
      nxt = pc + 4;
      case (instr[6:0])
        OPC_LUI:    val = {instr[31:12], 12'h000};
        OPC_AUIPC:  val = pc + {instr[31:12], 12'h000};
        OPC_OP:     val = alu(instr[14:12], instr[30], a, b);
        OPC_OP_IMM: val = alu(instr[14:12], instr[30] && (instr[14:12] == 3'b101), a,
                              word_t'($signed(instr[31:20])));
        OPC_JAL: begin
          val = pc + 4;
          taken = 1'b1;
          nxt = pc + word_t'($signed({instr[31], instr[19:12], instr[20], instr[30:21],
                                      1'b0}));
        end
        OPC_JALR: begin
          val = pc + 4;
          taken = 1'b1;
          nxt = (a + word_t'($signed(instr[31:20]))) & ~32'h1;
        end
        OPC_BRANCH: begin
          wr = 1'b0;
          taken = branch_taken(instr[14:12], a, b);
          if (taken) nxt = pc + word_t'($signed({instr[31], instr[7], instr[30:25],
                                                 instr[11:8], 1'b0}));
        end
        default: wr = 1'b0;                 // Bubble
      endcase
      if (pc == end_pc && end_slot < 0) end_slot = k;
      exp_addr_q[k] = pc;
      exp_wv_q[k] = wr && (rd != 0);
      exp_rd_q[k] = instr[11:7];
      exp_data_q[k] = val;
      if (wr && rd != 0) shadow[rd] = val;
      if (taken) begin
        for (int f = 1; f <= 3; f++) begin  // Fetched, then flushed
          exp_addr_q[k + f] = pc + word_t'(4 * f);
          exp_wv_q[k + f] = 1'b0;
          exp_rd_q[k + f] = '0;
          exp_data_q[k + f] = '0;
        end
        k += 4;
      end else begin
        k += 1;
      end
      pc = nxt;
    end
    model_len = k;
  endtask

  task automatic wait_for_retire(input word_t pc);
    do @(negedge clock);
    while (!(wb_valid && wb_pc == pc));
  endtask

  // ----------------------------------------------------------
  // Clock, ROM answer and expectations
  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(negedge clock) begin
    nedge = nedge + 1;
    ins_data = rom[ins_addr[9:2]];          // Word for the current fetch
    chk_reset = (nedge >= 1) && (nedge <= 4);
    chk_run = (nedge >= 4) && (nedge - 4 < model_len);
    exp_wv = 1'b0;
    if (chk_run) exp_addr = exp_addr_q[nedge - 4];
    if (chk_run && nedge >= 8) begin        // Retires four cycles after fetch
      exp_wv = exp_wv_q[nedge - 8];
      exp_rd = exp_rd_q[nedge - 8];
      exp_data = exp_data_q[nedge - 8];
      exp_pc = exp_addr_q[nedge - 8];
    end
  end

  initial begin
    reset = 1'b1;
    seed = 32'h84ef_38b7;
    build_program();
    run_model();
    limit_cycles = 4 + end_slot + 4 + 20;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    wait_for_retire(end_pc);
    repeat (3) @(negedge clock);
    $display("Errors: reset %0d, fetch %0d, retire %0d, total %0d",
             err_reset, err_fetch, err_retire, err_reset + err_fetch + err_retire);
    if (err_reset + err_fetch + err_retire == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clock);
    $display("Timeout: the last instruction did not retire in %0d cycles", limit_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  // ----------------------------------------------------------
  // Checks
  a_reset_addr: assert property (@(posedge clock) chk_reset |-> ins_addr == `RESET_PC)
    else begin
      err_reset++;
      $display("FAIL ins_addr in reset got %h exp %h", $sampled(ins_addr), `RESET_PC);
    end

  a_reset_wb: assert property (@(posedge clock) chk_reset |-> !wb_valid)
    else begin
      err_reset++;
      $display("FAIL wb_valid in reset got %h exp 0", $sampled(wb_valid));
    end

  a_fetch_addr: assert property (@(posedge clock) chk_run |-> ins_addr == exp_addr)
    else begin
      err_fetch++;
      $display("FAIL ins_addr got %h exp %h", $sampled(ins_addr), exp_addr);
    end

  a_wb_valid: assert property (@(posedge clock) chk_run |-> wb_valid == exp_wv)
    else begin
      err_retire++;
      $display("FAIL wb_valid got %h exp %h (wb_pc %h)", $sampled(wb_valid), exp_wv,
               $sampled(wb_pc));
    end

  a_wb_rd: assert property (@(posedge clock) (chk_run && exp_wv) |-> wb_rd == exp_rd)
    else begin
      err_retire++;
      $display("FAIL wb_rd got %h exp %h", $sampled(wb_rd), exp_rd);
    end

  a_wb_data: assert property (@(posedge clock) (chk_run && exp_wv) |-> wb_data == exp_data)
    else begin
      err_retire++;
      $display("FAIL wb_data got %h exp %h (pc %h)", $sampled(wb_data), exp_data, exp_pc);
    end

  a_wb_pc: assert property (@(posedge clock) (chk_run && exp_wv) |-> wb_pc == exp_pc)
    else begin
      err_retire++;
      $display("FAIL wb_pc got %h exp %h", $sampled(wb_pc), exp_pc);
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_unit.sv
src/gpr_file.sv
src/decode_unit.sv
src/issue_unit.sv
src/exec_unit.sv
src/core_top.sv
bench/core_tb.sv

/* Makefile */
SRCS := $(filter-out +incdir+%,$(shell cat verilog.f)) src/core_settings.svh

.PHONY: all run clean

all: run

obj_dir/Vcore_tb: verilog.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ns -f verilog.f --top-module core_tb -j 0

run: obj_dir/Vcore_tb
	@out="$$(./obj_dir/Vcore_tb)"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
